/* filelist.f */
+incdir+include
hdl/gb_bus_pkg.sv
hdl/gb_int_pkg.sv
hdl/bus_unit.sv
hdl/int_unit.sv
hdl/cpu_front.sv
test/tb_cpu_front.sv

/* hdl/bus_unit.sv */
`default_nettype none

module bus_unit (
    input  wire                      clk,
    input  wire                      rst,
    input  wire gb_bus_pkg::bus_op_t bus_op,
    input  wire gb_bus_pkg::addr_t   addr_in,
    input  wire gb_bus_pkg::byte_t   wdata,
    input  wire gb_bus_pkg::byte_t   din,
    input  wire                      imm_hi,
    output gb_bus_pkg::ct_t          ct,
    output logic                     phi,
    output logic                     rd,
    output logic                     wr,
    output gb_bus_pkg::addr_t        a,
    output gb_bus_pkg::byte_t        dout,
    output gb_bus_pkg::byte_t        opcode,
    output gb_bus_pkg::imm_word_u    imm,
    output logic                     fetch_strobe
);

    import gb_bus_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // T-cycle counter
    ////////////////////////////////////////////////////////////////////////////

    // Free running, wraps every machine cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ct <= CT_ADDR;
        end else begin
            ct <= ct + 2'd1;
        end
    end

    // High for the clock whose edge captures the opcode
    assign fetch_strobe = (ct == CT_DATA) && (bus_op == BUS_FETCH);

    ////////////////////////////////////////////////////////////////////////////
    // Bus sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a      <= '0;
            rd     <= 1'b0;
            wr     <= 1'b0;
            phi    <= 1'b1;
            dout   <= '0;
            opcode <= '0;
            imm    <= '0;
        end else begin
            case (ct)
                CT_ADDR: begin
                    a   <= addr_in;
                    rd  <= (bus_op == BUS_FETCH) || (bus_op == BUS_READ);
                    wr  <= 1'b0;
                    phi <= 1'b1;
                end
                CT_WAIT: begin
                    // Strobes held while memory responds
                end
                CT_DATA: begin
                    rd  <= 1'b0;
                    phi <= 1'b0;
                    case (bus_op)
                        BUS_WRITE: begin
                            wr   <= 1'b1;
                            dout <= wdata;
                        end
                        BUS_FETCH: begin
                            opcode <= din;      // Instruction boundary
                        end
                        BUS_READ: begin
                            imm.bytes[imm_hi] <= din;
                        end
                        BUS_NONE: begin
                            // Internal cycle, bus stays quiet
                        end
                    endcase
                end
                CT_IDLE: begin
                    rd   <= 1'b0;
                    wr   <= 1'b0;
                    dout <= '0;     // Release the data lines
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/cpu_front.sv */
`default_nettype none

module cpu_front (
    input  wire                       clk,
    input  wire                       rst,
    // Machine-cycle command
    input  wire gb_bus_pkg::bus_op_t   bus_op,
    input  wire gb_bus_pkg::addr_t     addr_in,
    input  wire gb_bus_pkg::byte_t     wdata,
    input  wire gb_bus_pkg::byte_t     din,
    input  wire                       imm_hi,
    // Interrupt and power state
    input  wire gb_int_pkg::int_vec_t  int_en,
    input  wire gb_int_pkg::int_vec_t  int_flags_in,
    input  wire gb_int_pkg::key_t      key_in,
    input  wire                       ime,
    input  wire                       halt,
    input  wire                       stop,
    input  wire                       int_ack,
    input  wire                       vector_take,
    // External bus
    output wire gb_bus_pkg::ct_t       ct,
    output wire                       phi,
    output wire                       rd,
    output wire                       wr,
    output wire gb_bus_pkg::addr_t     a,
    output wire gb_bus_pkg::byte_t     dout,
    output wire gb_bus_pkg::byte_t     opcode,
    output wire gb_bus_pkg::imm_word_u imm,
    // Interrupt results
    output wire gb_int_pkg::int_vec_t  int_flags_out,
    output wire gb_bus_pkg::addr_t     int_vector,
    output wire                       int_dispatch,
    output wire                       wake
);

    wire fetch_strobe;      // Opcode capture clock

    bus_unit bus_unit_i (
        .clk          (clk),
        .rst          (rst),
        .bus_op       (bus_op),
        .addr_in      (addr_in),
        .wdata        (wdata),
        .din          (din),
        .imm_hi       (imm_hi),
        .ct           (ct),
        .phi          (phi),
        .rd           (rd),
        .wr           (wr),
        .a            (a),
        .dout         (dout),
        .opcode       (opcode),
        .imm          (imm),
        .fetch_strobe (fetch_strobe)
    );

    int_unit int_unit_i (
        .clk           (clk),
        .rst           (rst),
        .ct            (ct),
        .fetch_strobe  (fetch_strobe),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .key_in        (key_in),
        .ime           (ime),
        .halt          (halt),
        .stop          (stop),
        .int_ack       (int_ack),
        .vector_take   (vector_take),
        .int_flags_out (int_flags_out),
        .int_vector    (int_vector),
        .int_dispatch  (int_dispatch),
        .wake          (wake)
    );

endmodule

`default_nettype wire

/* hdl/gb_bus_pkg.sv */
`default_nettype none

package gb_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int CT_W   = 2;      // Four T-cycles per machine cycle
    localparam int OP_W   = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [CT_W-1:0]   ct_t;
    typedef logic [OP_W-1:0]   bus_op_t;

    // T-cycle numbering inside one machine cycle
    localparam ct_t CT_ADDR = 2'd0;     // Address setup, strobes launched
    localparam ct_t CT_WAIT = 2'd1;     // Memory access in flight
    localparam ct_t CT_DATA = 2'd2;     // Read data sampled, write data driven
    localparam ct_t CT_IDLE = 2'd3;     // Bus released

    // Machine-cycle bus operations
    localparam bus_op_t BUS_NONE  = 2'b00;
    localparam bus_op_t BUS_FETCH = 2'b01;
    localparam bus_op_t BUS_WRITE = 2'b10;
    localparam bus_op_t BUS_READ  = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // Immediate operand
    ////////////////////////////////////////////////////////////////////////////

    // Filled one byte per read cycle, used as a 16-bit address afterwards
    typedef union packed {
        addr_t       word;
        byte_t [1:0] bytes;     // [1] high byte, [0] low byte
    } imm_word_u;

endpackage

`default_nettype wire

/* hdl/gb_int_pkg.sv */
`default_nettype none

package gb_int_pkg;

    // Interrupt sources, lowest index wins
    localparam int NUM_INT = 5;
    localparam int KEY_W   = 8;

    typedef logic [NUM_INT-1:0] int_vec_t;
    typedef logic [KEY_W-1:0]   key_t;     // Keypad lines, high when pressed

    ////////////////////////////////////////////////////////////////////////////
    // Restart vectors
    ////////////////////////////////////////////////////////////////////////////

    localparam gb_bus_pkg::addr_t INT_VECTOR_BASE   = 16'h0040;
    localparam int                INT_VECTOR_STRIDE = 8;

    // Dispatch whose source vanished before the vector was taken
    localparam gb_bus_pkg::addr_t INT_NONE_VECTOR   = 16'h0000;

    // Source order in the flag vector
    localparam int INT_VBLANK = 0;      // Vector 0x40
    localparam int INT_LCDC   = 1;      // Vector 0x48
    localparam int INT_TIMER  = 2;      // Vector 0x50
    localparam int INT_SERIAL = 3;      // Vector 0x58
    localparam int INT_JOYPAD = 4;      // Vector 0x60

endpackage

`default_nettype wire

/* hdl/int_unit.sv */
`default_nettype none

module int_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire gb_bus_pkg::ct_t      ct,
    input  wire                       fetch_strobe,
    input  wire gb_int_pkg::int_vec_t int_en,
    input  wire gb_int_pkg::int_vec_t int_flags_in,
    input  wire gb_int_pkg::key_t     key_in,
    input  wire                       ime,
    input  wire                       halt,
    input  wire                       stop,
    input  wire                       int_ack,
    input  wire                       vector_take,
    output gb_int_pkg::int_vec_t      int_flags_out,
    output gb_bus_pkg::addr_t         int_vector,
    output logic                      int_dispatch,
    output logic                      wake
);

    import gb_bus_pkg::*;
    import gb_int_pkg::*;

    int_vec_t masked;       // Pending, enabled and allowed by IME
    int_vec_t served;       // One-hot, highest-priority masked source
    logic     pending;      // Enabled request, IME ignored
    logic     wake_cond;
    logic     wake_dly;

    ////////////////////////////////////////////////////////////////////////////
    // Priority and vector
    ////////////////////////////////////////////////////////////////////////////

    assign masked = int_flags_in & int_en & {NUM_INT{ime}};

    // Walk down so the lowest set bit is the last one written
    always_comb begin
        served     = '0;
        int_vector = INT_NONE_VECTOR;
        for (int i = NUM_INT - 1; i >= 0; i--) begin
            if (masked[i]) begin
                served     = '0;
                served[i]  = 1'b1;
                int_vector = INT_VECTOR_BASE + addr_t'(i * INT_VECTOR_STRIDE);
            end
        end
    end

    // Serviced flag drops only while the vector is being loaded
    assign int_flags_out = (int_dispatch && vector_take) ? (int_flags_in & ~served)
                                                          : int_flags_in;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch latch
    ////////////////////////////////////////////////////////////////////////////

    // Only sampled on opcode fetches, so it sits on instruction boundaries
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            int_dispatch <= 1'b0;
        end else if (fetch_strobe) begin
            if (!int_dispatch && (masked != '0)) begin
                int_dispatch <= 1'b1;
            end else if (int_dispatch && int_ack) begin
                int_dispatch <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Halt and stop wake
    ////////////////////////////////////////////////////////////////////////////

    assign pending = (int_flags_in & int_en) != '0;

    // IME plays no part in waking
    // A keypress also ends stop
    always_comb begin
        if (halt) begin
            wake_cond = pending;
        end else if (stop) begin
            wake_cond = pending || (key_in != '0);
        end else begin
            wake_cond = 1'b0;
        end
    end

    // One machine cycle of delay before the core resumes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wake_dly <= 1'b0;
            wake     <= 1'b0;
        end else if (ct == CT_DATA) begin
            wake_dly <= wake_cond;
            wake     <= wake_dly;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the cpu_front testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_cpu_front -f filelist.f --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cpu_front)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* test/cpu_front_tests.txt */
# op addr wdat din rnd hi en flg ime hlt stp key ack tak x_opc x_imm x_vec x_flg x_dsp x_wak
# All hex. op 0 none 1 fetch 2 write 3 read, rnd 1 replaces din with a random byte
1 0100 00 3e 0 0 00 00 0 0 0 00 0 0 3e 0000 0000 00 0 0
3 0101 00 34 0 0 00 00 0 0 0 00 0 0 3e 0034 0000 00 0 0
3 0102 00 12 0 1 00 00 0 0 0 00 0 0 3e 1234 0000 00 0 0
2 c000 a5 00 0 0 00 00 0 0 0 00 0 0 3e 1234 0000 00 0 0
1 0103 00 00 1 0 00 00 0 0 0 00 0 0 00 1234 0000 00 0 0
0 0000 00 00 1 0 00 00 0 0 0 00 0 0 00 1234 0000 00 0 0
0 0000 00 00 0 0 1f 0c 1 0 0 00 0 0 00 1234 0050 0c 0 0
1 0104 00 cd 0 0 1f 0c 1 0 0 00 0 0 cd 1234 0050 0c 1 0
0 0000 00 00 0 0 1f 0c 1 0 0 00 0 1 cd 1234 0050 08 1 0
2 ff0f 77 00 0 0 1f 1a 1 0 0 00 0 1 cd 1234 0048 18 1 0
1 0050 00 c9 0 0 1f 1a 1 0 0 00 0 0 c9 1234 0048 1a 1 0
1 0051 00 76 0 0 1f 1a 1 0 0 00 1 1 76 1234 0048 1a 0 0
1 0052 00 00 0 0 1f 1a 0 0 0 00 0 0 00 1234 0000 1a 0 0
1 0053 00 fb 0 0 1f 00 1 0 0 00 0 0 fb 1234 0000 00 0 0
0 0000 00 00 0 0 10 1f 1 0 0 00 0 0 fb 1234 0060 1f 0 0
0 0000 00 00 0 0 01 01 0 1 0 00 0 0 fb 1234 0000 01 0 0
0 0000 00 00 0 0 01 01 0 1 0 00 0 0 fb 1234 0000 01 0 1
0 0000 00 00 0 0 01 01 0 0 0 00 0 0 fb 1234 0000 01 0 1
0 0000 00 00 0 0 01 01 0 0 0 00 0 0 fb 1234 0000 01 0 0
0 0000 00 00 0 0 00 00 0 0 1 04 0 0 fb 1234 0000 00 0 0
0 0000 00 00 0 0 00 00 0 0 1 04 0 0 fb 1234 0000 00 0 1
0 0000 00 00 0 0 00 00 0 0 0 04 0 0 fb 1234 0000 00 0 1
0 0000 00 00 0 0 00 00 0 0 0 04 0 0 fb 1234 0000 00 0 0
0 0000 00 00 0 0 00 00 0 1 0 08 0 0 fb 1234 0000 00 0 0
0 0000 00 00 0 0 00 00 0 1 0 08 0 0 fb 1234 0000 00 0 0
0 0000 00 00 0 0 01 02 0 1 0 00 0 0 fb 1234 0000 02 0 0
0 0000 00 00 0 0 01 02 0 1 0 00 0 0 fb 1234 0000 02 0 0
3 0200 00 78 0 0 00 00 0 0 0 00 0 0 fb 1278 0000 00 0 0

/* include/tb_compare_tasks.svh */
`ifndef TB_COMPARE_TASKS_SVH
`define TB_COMPARE_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Checkers for the cpu_front testbench
////////////////////////////////////////////////////////////////////////////

// First mismatch ends the run
task automatic fail_compare(input string name, input string got_s, input string exp_s);
    $display("FAILED at %0t ns: %s is %s, expected %s", $time, name, got_s, exp_s);
    $display("Result: FAILED");
    $fatal(1, "%s mismatch", name);
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_compare(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
endtask

task automatic compare_byte(input string name, input gb_bus_pkg::byte_t got,
                            input gb_bus_pkg::byte_t exp);
    if (got !== exp) begin
        fail_compare(name, $sformatf("0x%02h", got), $sformatf("0x%02h", exp));
    end
endtask

task automatic compare_addr(input string name, input gb_bus_pkg::addr_t got,
                            input gb_bus_pkg::addr_t exp);
    if (got !== exp) begin
        fail_compare(name, $sformatf("0x%04h", got), $sformatf("0x%04h", exp));
    end
endtask

task automatic compare_int_vec(input string name, input gb_int_pkg::int_vec_t got,
                               input gb_int_pkg::int_vec_t exp);
    if (got !== exp) begin
        fail_compare(name, $sformatf("%05b", got), $sformatf("%05b", exp));
    end
endtask

// Word view compared, bytes shown for the hi/lo capture order
task automatic compare_imm(input string name, input gb_bus_pkg::imm_word_u got,
                           input gb_bus_pkg::imm_word_u exp);
    if (got.word !== exp.word) begin
        fail_compare(name,
                     $sformatf("0x%04h (hi 0x%02h lo 0x%02h)",
                               got.word, got.bytes[1], got.bytes[0]),
                     $sformatf("0x%04h", exp.word));
    end
endtask

`endif

/* test/tb_cpu_front.sv */
`default_nettype none

module tb_cpu_front;

    timeunit 1ns;
    timeprecision 1ps;

    import gb_bus_pkg::*;
    import gb_int_pkg::*;

    `include "tb_compare_tasks.svh"

    // One machine cycle of stimulus and its expected results
    typedef struct packed {
        bus_op_t  op;
        addr_t    addr;
        byte_t    wdata;
        byte_t    din;
        logic     rnd;          // din comes from the random source
        logic     hi;
        int_vec_t en;
        int_vec_t flags;
        logic     ime;
        logic     halt;
        logic     stop;
        key_t     key;
        logic     ack;
        logic     take;
        byte_t    x_opcode;     // Checked on fetches only
        addr_t    x_imm;        // Checked on reads only
        addr_t    x_vector;
        int_vec_t x_flags;
        logic     x_dispatch;
        logic     x_wake;
    } record_t;

    logic      clk;
    logic      rst;
    bus_op_t   bus_op;
    addr_t     addr_in;
    byte_t     wdata;
    byte_t     din;
    logic      imm_hi;
    int_vec_t  int_en;
    int_vec_t  int_flags_in;
    key_t      key_in;
    logic      ime;
    logic      halt;
    logic      stop;
    logic      int_ack;
    logic      vector_take;
    ct_t       ct;
    logic      phi;
    logic      rd;
    logic      wr;
    addr_t     a;
    byte_t     dout;
    byte_t     opcode;
    imm_word_u imm;
    int_vec_t  int_flags_out;
    addr_t     int_vector;
    logic      int_dispatch;
    logic      wake;

    record_t records[$];
    int      seed = 5366;
    int      watchdog_ns = 0;   // Set once the records are loaded

    cpu_front dut_i (
        .clk           (clk),
        .rst           (rst),
        .bus_op        (bus_op),
        .addr_in       (addr_in),
        .wdata         (wdata),
        .din           (din),
        .imm_hi        (imm_hi),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .key_in        (key_in),
        .ime           (ime),
        .halt          (halt),
        .stop          (stop),
        .int_ack       (int_ack),
        .vector_take   (vector_take),
        .ct            (ct),
        .phi           (phi),
        .rd            (rd),
        .wr            (wr),
        .a             (a),
        .dout          (dout),
        .opcode        (opcode),
        .imm           (imm),
        .int_flags_out (int_flags_out),
        .int_vector    (int_vector),
        .int_dispatch  (int_dispatch),
        .wake          (wake)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Record loading and per-cycle checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        int unsigned v [20];
        record_t     rec;
        fd = $fopen("test/cpu_front_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test record file");
            $display("Result: FAILED");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;       // Column header or blank line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                        v[19]);
            if (n != 20) begin
                $display("Malformed test record, %0d fields in: %s", n, line);
                $display("Result: FAILED");
                $fatal(1, "bad record");
            end
            rec.op         = bus_op_t'(v[0]);
            rec.addr       = addr_t'(v[1]);
            rec.wdata      = byte_t'(v[2]);
            rec.din        = byte_t'(v[3]);
            rec.rnd        = v[4][0];
            rec.hi         = v[5][0];
            rec.en         = int_vec_t'(v[6]);
            rec.flags      = int_vec_t'(v[7]);
            rec.ime        = v[8][0];
            rec.halt       = v[9][0];
            rec.stop       = v[10][0];
            rec.key        = key_t'(v[11]);
            rec.ack        = v[12][0];
            rec.take       = v[13][0];
            rec.x_opcode   = byte_t'(v[14]);
            rec.x_imm      = addr_t'(v[15]);
            rec.x_vector   = addr_t'(v[16]);
            rec.x_flags    = int_vec_t'(v[17]);
            rec.x_dispatch = v[18][0];
            rec.x_wake     = v[19][0];
            records.push_back(rec);
        end
        $fclose(fd);
        if (records.size() == 0) begin
            $display("The test record file holds no records");
            $display("Result: FAILED");
            $fatal(1, "empty stimulus");
        end
    endtask

    task automatic check_strobes(input ct_t ct_exp, input logic phi_exp,
                                 input logic rd_exp, input logic wr_exp);
        compare_byte("ct", byte_t'(ct), byte_t'(ct_exp));
        compare_bit("phi", phi, phi_exp);
        compare_bit("rd", rd, rd_exp);
        compare_bit("wr", wr, wr_exp);
    endtask

    task automatic run_record(input record_t r);
        byte_t     din_val;
        logic      is_write;
        logic      exp_rd;
        imm_word_u exp_imm;
        din_val      = r.rnd ? byte_t'($random(seed)) : r.din;
        is_write     = (r.op == BUS_WRITE);
        exp_rd       = (r.op == BUS_FETCH) || (r.op == BUS_READ);
        exp_imm.word = r.x_imm;
        // Back to back records need no extra wait
        while (ct !== CT_IDLE) begin
            @(negedge clk);
        end
        @(posedge clk);     // ct returns to CT_ADDR here
        bus_op       <= r.op;
        addr_in      <= r.addr;
        wdata        <= r.wdata;
        din          <= din_val;
        imm_hi       <= r.hi;
        int_en       <= r.en;
        int_flags_in <= r.flags;
        ime          <= r.ime;
        halt         <= r.halt;
        stop         <= r.stop;
        key_in       <= r.key;
        int_ack      <= r.ack;
        vector_take  <= r.take;
        @(negedge clk);
        check_strobes(CT_ADDR, 1'b0, 1'b0, 1'b0);
        compare_byte("dout", dout, 8'h00);
        @(negedge clk);
        check_strobes(CT_WAIT, 1'b1, exp_rd, 1'b0);
        compare_addr("a", a, r.addr);
        @(negedge clk);
        check_strobes(CT_DATA, 1'b1, exp_rd, 1'b0);
        compare_addr("a", a, r.addr);
        @(negedge clk);
        check_strobes(CT_IDLE, 1'b0, 1'b0, is_write);
        compare_byte("dout", dout, is_write ? r.wdata : 8'h00);
        if (r.op == BUS_FETCH) begin
            compare_byte("opcode", opcode, r.rnd ? din_val : r.x_opcode);
        end
        if (r.op == BUS_READ) begin
            compare_imm("imm", imm, exp_imm);
        end
        compare_addr("int_vector", int_vector, r.x_vector);
        compare_int_vec("int_flags_out", int_flags_out, r.x_flags);
        compare_bit("int_dispatch", int_dispatch, r.x_dispatch);
        compare_bit("wake", wake, r.x_wake);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst          = 1'b1;
        bus_op       = BUS_NONE;
        addr_in      = '0;
        wdata        = '0;
        din          = '0;
        imm_hi       = 1'b0;
        int_en       = '0;
        int_flags_in = '0;
        key_in       = '0;
        ime          = 1'b0;
        halt         = 1'b0;
        stop         = 1'b0;
        int_ack      = 1'b0;
        vector_take  = 1'b0;
        load_records();
        // Four clocks per record, plus reset and some slack
        watchdog_ns = records.size() * 4 * 100 + 10 * 100 + 2000;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        foreach (records[i]) begin
            run_record(records[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: the test records did not finish within %0d ns", watchdog_ns);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
